// ==== wiscCore.f ====
cpuPkg.sv
controlUnit.sv
executeUnit.sv
regFile.sv
fetchUnit.sv
wbMaster.sv
wiscCore.sv
coreChecker.sv
tbWiscCore.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tbWiscCore
FILELIST  = wiscCore.f
OBJDIR    = obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJDIR)

// ==== tbWiscCore.sv ====
module tbWiscCore;
    timeunit 1ns;
    timeprecision 1ps;

    logic             clk;
    logic             rst;
    logic [15:0]      instrAddr;
    logic [15:0]      instr;
    cpuPkg::wbReqT    wbReq;
    cpuPkg::wbRspT    wbRsp;
    logic             fftCalculating;
    cpuPkg::accelCmdT accelCmd;
    logic             halted;
    logic [15:0]      rom [256];
    logic [15:0]      mem [256];
    logic [4:0]       opTable [29];
    logic [31:0]      lcgState = 32'h6ee9;
    logic [1:0]       waitCnt;
    logic [15:0]      r;
    logic [15:0]      r2;
    int               topErrors;
    int               cycles;
    int               errorCount;
    int               checkCount;
    int               retireCount;

    function logic [15:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    // Instruction fetch is combinational
    assign instr = rom[instrAddr[8:1]];

    wiscCore wiscCore_inst (
        .clk            (clk),
        .rst            (rst),
        .instrAddr      (instrAddr),
        .instr          (instr),
        .wbReq          (wbReq),
        .wbRsp          (wbRsp),
        .fftCalculating (fftCalculating),
        .accelCmd       (accelCmd),
        .halted         (halted)
    );

    coreChecker checker_inst (
        .clk            (clk),
        .rst            (rst),
        .instrAddr      (instrAddr),
        .instr          (instr),
        .wbReq          (wbReq),
        .wbRsp          (wbRsp),
        .fftCalculating (fftCalculating),
        .accelCmd       (accelCmd),
        .halted         (halted),
        .errorCount     (errorCount),
        .checkCount     (checkCount),
        .retireCount    (retireCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Busy toggling and Wishbone slave with 0 to 3 wait states
    always begin
        @(posedge clk);
        #1;
        r = nextRand();
        if (r[1:0] == 2'b00) fftCalculating = ~fftCalculating;
        if (rst) begin
            wbRsp.ack = 1'b0;
            waitCnt = r[3:2];
        end else if (wbRsp.ack) begin
            // Edge with ack closed the cycle
            wbRsp.ack = 1'b0;
            waitCnt = r[3:2];
        end else if (wbReq.cyc && wbReq.stb) begin
            if (waitCnt == 2'd0) begin
                wbRsp.ack = 1'b1;
                wbRsp.datR = mem[wbReq.adr[7:0]];
                // Store takes effect with the ack
                if (wbReq.we) mem[wbReq.adr[7:0]] = wbReq.datW;
            end else begin
                waitCnt = waitCnt - 2'd1;
            end
        end else begin
            waitCnt = r[3:2];
        end
    end

    initial begin
        rst = 1'b1;
        fftCalculating = 1'b0;
        wbRsp = '0;
        waitCnt = 2'd0;
        topErrors = 0;
        opTable = '{cpuPkg::opNop, cpuPkg::opStartF, cpuPkg::opStartI, cpuPkg::opLoadF,
                    cpuPkg::opAddi, cpuPkg::opSubi, cpuPkg::opXori, cpuPkg::opAndni,
                    cpuPkg::opSt, cpuPkg::opLd, cpuPkg::opStu, cpuPkg::opAdd,
                    cpuPkg::opSub, cpuPkg::opXor, cpuPkg::opAndn, cpuPkg::opSeq,
                    cpuPkg::opSlt, cpuPkg::opSle, cpuPkg::opBeqz, cpuPkg::opBnez,
                    cpuPkg::opBltz, cpuPkg::opBgez, cpuPkg::opLbi, cpuPkg::opSlbi,
                    cpuPkg::opJr, cpuPkg::opJalr, cpuPkg::opJ, cpuPkg::opJal,
                    cpuPkg::opRfe};
        for (int i = 0; i < 256; i++) begin
            r = nextRand();
            r2 = nextRand();
            rom[i] = {opTable[int'(r % 16'd29)], r2[10:0]};
            mem[i] = {i[7:0], ~i[7:0]};
        end
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // Random program under the model
        cycles = 0;
        while (retireCount < 1500 && cycles < 40000) begin
            @(posedge clk);
            cycles++;
        end
        if (retireCount < 1500) begin
            topErrors++;
            $display("timeout while waiting for instructions to retire");
        end

        // Halt at word 5 after a fresh reset
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            rom[i] = (i == 5) ? {cpuPkg::opHalt, 11'b0} : {cpuPkg::opNop, 11'b0};
        end
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        cycles = 0;
        while (!halted && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            topErrors++;
            $display("timeout while waiting for the core to halt");
        end
        // Model keeps comparing the frozen core
        repeat (50) @(posedge clk);

        $display("checks %0d errors %0d retired %0d", checkCount,
                 errorCount + topErrors, retireCount);
        if (errorCount + topErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== coreChecker.sv ====
module coreChecker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cpuPkg::dataWidth-1:0] instrAddr,
    input  logic [cpuPkg::dataWidth-1:0] instr,
    input  cpuPkg::wbReqT                wbReq,
    input  cpuPkg::wbRspT                wbRsp,
    input  logic                         fftCalculating,
    input  cpuPkg::accelCmdT             accelCmd,
    input  logic                         halted,
    output int                           errorCount,
    output int                           checkCount,
    output int                           retireCount
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] regs [8];
    logic [15:0] mem [256];
    logic [15:0] pc;
    logic [15:0] nextPc;
    logic [15:0] addr;
    logic [15:0] wordAdr;
    logic [15:0] imm5s;
    logic [15:0] imm5z;
    logic [15:0] imm8s;
    logic [15:0] imm8z;
    logic [15:0] disp;
    logic [4:0]  opc;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [2:0]  rd;
    logic [2:0]  expCmd;
    logic        modelHalted;
    logic        isMem;
    logic        advance;
    // Bus state seen at the previous edge
    logic        prevOpen;
    logic        prevDone;

    task compareValue(input string name, input logic [15:0] expected, input logic [15:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task reportFault(input string what);
        errorCount++;
        $display("%s at time %0t", what, $time);
    endtask

    // One instruction of the ISA, or a held cycle
    task stepModel();
        opc = instr[15:11];
        rs = instr[10:8];
        rt = instr[7:5];
        rd = instr[4:2];
        imm5s = {{11{instr[4]}}, instr[4:0]};
        imm5z = {11'b0, instr[4:0]};
        imm8s = {{8{instr[7]}}, instr[7:0]};
        imm8z = {8'b0, instr[7:0]};
        disp = {{5{instr[10]}}, instr[10:0]};
        isMem = (opc == cpuPkg::opSt) || (opc == cpuPkg::opLd) || (opc == cpuPkg::opStu);
        // Memory waits for ack, starts wait for an idle accelerator
        if (isMem) begin
            advance = wbReq.cyc & wbRsp.ack;
        end else if (opc == cpuPkg::opStartF || opc == cpuPkg::opStartI) begin
            advance = ~fftCalculating;
        end else begin
            advance = 1'b1;
        end
        expCmd = 3'b000;
        if (opc == cpuPkg::opStartF) expCmd = {~fftCalculating, 2'b00};
        if (opc == cpuPkg::opStartI) expCmd = {1'b0, ~fftCalculating, 1'b0};
        if (opc == cpuPkg::opLoadF) expCmd = 3'b001;
        compareValue("accel", {13'b0, expCmd}, {13'b0, accelCmd});

        addr = regs[rs] + imm5s;
        wordAdr = {1'b0, addr[15:1]};
        if (isMem && advance) begin
            compareValue("bus adr", wordAdr, wbReq.adr);
            compareValue("bus we", {15'b0, opc != cpuPkg::opLd}, {15'b0, wbReq.we});
            if (opc != cpuPkg::opLd) begin
                compareValue("store data", regs[rt], wbReq.datW);
            end
        end
        // No bus traffic outside loads and stores
        if (!isMem) begin
            compareValue("idle cyc", 16'd0, {15'b0, wbReq.cyc});
        end
        if (!advance) return;

        retireCount++;
        nextPc = pc + 16'd2;
        case (opc)
            cpuPkg::opHalt: begin
                modelHalted = 1'b1;
                nextPc = pc;
            end
            cpuPkg::opAddi: regs[rt] = regs[rs] + imm5s;
            // Reverse subtract, operand minus rs
            cpuPkg::opSubi: regs[rt] = imm5s - regs[rs];
            cpuPkg::opXori: regs[rt] = regs[rs] ^ imm5z;
            cpuPkg::opAndni: regs[rt] = regs[rs] & ~imm5z;
            cpuPkg::opSt: mem[wordAdr[7:0]] = regs[rt];
            cpuPkg::opLd: regs[rt] = mem[wordAdr[7:0]];
            cpuPkg::opStu: begin
                mem[wordAdr[7:0]] = regs[rt];
                regs[rs] = addr;
            end
            cpuPkg::opAdd: regs[rd] = regs[rs] + regs[rt];
            cpuPkg::opSub: regs[rd] = regs[rt] - regs[rs];
            cpuPkg::opXor: regs[rd] = regs[rs] ^ regs[rt];
            cpuPkg::opAndn: regs[rd] = regs[rs] & ~regs[rt];
            cpuPkg::opSeq: regs[rd] = {15'b0, regs[rs] == regs[rt]};
            cpuPkg::opSlt: regs[rd] = {15'b0, $signed(regs[rs]) < $signed(regs[rt])};
            cpuPkg::opSle: regs[rd] = {15'b0, $signed(regs[rs]) <= $signed(regs[rt])};
            cpuPkg::opBeqz: if (regs[rs] == 16'd0) nextPc = nextPc + imm8s;
            cpuPkg::opBnez: if (regs[rs] != 16'd0) nextPc = nextPc + imm8s;
            cpuPkg::opBltz: if (regs[rs][15]) nextPc = nextPc + imm8s;
            cpuPkg::opBgez: if (!regs[rs][15]) nextPc = nextPc + imm8s;
            cpuPkg::opLbi: regs[rs] = imm8s;
            cpuPkg::opSlbi: regs[rs] = {regs[rs][7:0], 8'b0} | imm8z;
            cpuPkg::opJr: nextPc = regs[rs] + imm8s;
            cpuPkg::opJalr: begin
                // Target from the old rs, then link
                nextPc = regs[rs] + imm8s;
                regs[7] = pc + 16'd2;
            end
            cpuPkg::opJ: nextPc = nextPc + disp;
            cpuPkg::opJal: begin
                nextPc = nextPc + disp;
                regs[7] = pc + 16'd2;
            end
            default: begin
            end
        endcase
        pc = nextPc;
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        retireCount = 0;
        // Same fill as the bus memory
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            pc = 16'd0;
            modelHalted = 1'b0;
            prevOpen = 1'b0;
            prevDone = 1'b0;
            for (int i = 0; i < 8; i++) begin
                regs[i] = 16'd0;
            end
        end else begin
            compareValue("pc", pc, instrAddr);
            compareValue("halted", {15'b0, modelHalted}, {15'b0, halted});
            compareValue("stb", {15'b0, wbReq.cyc}, {15'b0, wbReq.stb});
            if (prevOpen && !wbReq.cyc) reportFault("bus cycle dropped before ack");
            if (prevDone && wbReq.cyc) reportFault("no idle cycle after ack");
            prevOpen = wbReq.cyc & ~wbRsp.ack;
            prevDone = wbReq.cyc & wbRsp.ack;
            if (modelHalted) begin
                compareValue("halt accel", 16'd0, {13'b0, accelCmd});
                compareValue("halt cyc", 16'd0, {15'b0, wbReq.cyc});
            end else begin
                stepModel();
            end
        end
    end

endmodule

// ==== wiscCore.sv ====
module wiscCore (
    input  logic                         clk,
    input  logic                         rst,
    output logic [cpuPkg::dataWidth-1:0] instrAddr,
    input  logic [cpuPkg::dataWidth-1:0] instr,
    output cpuPkg::wbReqT                wbReq,
    input  cpuPkg::wbRspT                wbRsp,
    input  logic                         fftCalculating,
    output cpuPkg::accelCmdT             accelCmd,
    output logic                         halted
);

    cpuPkg::ctrlT                    ctrl;
    logic                            blockInstruction;
    logic [cpuPkg::dataWidth-1:0]    rsData;
    logic [cpuPkg::dataWidth-1:0]    rtData;
    logic [cpuPkg::dataWidth-1:0]    aluResult;
    logic                            branchTaken;
    logic [cpuPkg::dataWidth-1:0]    jrTarget;
    logic [cpuPkg::dataWidth-1:0]    pc;
    logic [cpuPkg::dataWidth-1:0]    pcPlus2;
    logic [cpuPkg::dataWidth-1:0]    loadData;
    logic                            memDone;
    logic                            memBusy;
    logic                            stall;
    logic [cpuPkg::regAddrWidth-1:0] writeAddr;
    logic [cpuPkg::dataWidth-1:0]    writeData;
    logic                            writeEnable;

    assign instrAddr = pc;
    // Bus wait or blocked start holds the PC
    assign stall = memBusy | blockInstruction;

    // Destination: link, rd of R form, rs, else rd of I form
    assign writeAddr = ctrl.isJal ? cpuPkg::linkReg :
                       ctrl.regDst ? instr[4:2] :
                       ctrl.rsWrite ? instr[10:8] : instr[7:5];
    assign writeData = ctrl.isJal ? pcPlus2 :
                       ctrl.memToReg ? loadData : aluResult;
    // Loads write on ack, STU once its store is done
    assign writeEnable = ctrl.regWrite & (ctrl.memToReg ? memDone : ~memBusy);

    controlUnit controlUnit_inst (
        .opcode           (instr[cpuPkg::dataWidth-1 -: cpuPkg::opcodeWidth]),
        .fftCalculating   (fftCalculating),
        .ctrl             (ctrl),
        .accelCmd         (accelCmd),
        .blockInstruction (blockInstruction)
    );

    regFile regFile_inst (
        .clk         (clk),
        .rst         (rst),
        .rsAddr      (instr[10:8]),
        .rtAddr      (instr[7:5]),
        .writeAddr   (writeAddr),
        .writeEnable (writeEnable),
        .writeData   (writeData),
        .rsData      (rsData),
        .rtData      (rtData)
    );

    executeUnit executeUnit_inst (
        .ctrl        (ctrl),
        .instr       (instr),
        .rsData      (rsData),
        .rtData      (rtData),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .jrTarget    (jrTarget)
    );

    fetchUnit fetchUnit_inst (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .branchTaken (branchTaken),
        .jrTarget    (jrTarget),
        .instr       (instr),
        .stall       (stall),
        .pc          (pc),
        .pcPlus2     (pcPlus2),
        .halted      (halted)
    );

    // Store data comes from rd of the I form
    wbMaster wbMaster_inst (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .storeData (rtData),
        .wbRsp     (wbRsp),
        .wbReq     (wbReq),
        .loadData  (loadData),
        .memDone   (memDone),
        .memBusy   (memBusy)
    );

endmodule

// ==== wbMaster.sv ====
module wbMaster (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::ctrlT                 ctrl,
    input  logic [cpuPkg::dataWidth-1:0] aluResult,
    input  logic [cpuPkg::dataWidth-1:0] storeData,
    input  cpuPkg::wbRspT                wbRsp,
    output cpuPkg::wbReqT                wbReq,
    output logic [cpuPkg::dataWidth-1:0] loadData,
    output logic                         memDone,
    output logic                         memBusy
);

    logic memOp;
    logic req;
    // High for the cycle after an ack
    logic closing;

    assign memOp = ctrl.memRead | ctrl.memWrite;
    // Forced idle cycle between back-to-back accesses
    assign req = memOp & ~closing;

    assign wbReq.cyc = req;
    assign wbReq.stb = req;
    assign wbReq.we = ctrl.memWrite;
    // Word address from the byte address
    assign wbReq.adr = {1'b0, aluResult[cpuPkg::dataWidth-1:1]};
    assign wbReq.datW = storeData;

    assign memDone = req & wbRsp.ack;
    assign memBusy = memOp & ~memDone;
    assign loadData = wbRsp.datR;

    always_ff @(posedge clk) begin
        if (rst) begin
            closing <= 1'b0;
        end else begin
            closing <= memDone;
        end
    end

endmodule

// ==== fetchUnit.sv ====
module fetchUnit (
    input  logic                         clk,
    input  logic                         rst,
    input  cpuPkg::ctrlT                 ctrl,
    input  logic                         branchTaken,
    input  logic [cpuPkg::dataWidth-1:0] jrTarget,
    input  logic [cpuPkg::dataWidth-1:0] instr,
    input  logic                         stall,
    output logic [cpuPkg::dataWidth-1:0] pc,
    output logic [cpuPkg::dataWidth-1:0] pcPlus2,
    output logic                         halted
);

    logic [cpuPkg::dataWidth-1:0] branchTarget;
    logic [cpuPkg::dataWidth-1:0] jumpTarget;
    logic [cpuPkg::dataWidth-1:0] nextPc;

    assign pcPlus2 = pc + cpuPkg::pcStep;
    // Offsets are relative to the following instruction
    assign branchTarget = pcPlus2 + {{8{instr[7]}}, instr[7:0]};
    assign jumpTarget = pcPlus2 + {{5{instr[10]}}, instr[10:0]};

    always_comb begin
        if (ctrl.isJr) begin
            nextPc = jrTarget;
        end else if (ctrl.isJump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            halted <= 1'b0;
        end else if (!stall && !halted) begin
            // PC stays on the halt instruction
            if (ctrl.halt) begin
                halted <= 1'b1;
            end else begin
                pc <= nextPc;
            end
        end
    end

endmodule

// ==== regFile.sv ====
module regFile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cpuPkg::regAddrWidth-1:0] rsAddr,
    input  logic [cpuPkg::regAddrWidth-1:0] rtAddr,
    input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input  logic                            writeEnable,
    input  logic [cpuPkg::dataWidth-1:0]    writeData,
    output logic [cpuPkg::dataWidth-1:0]    rsData,
    output logic [cpuPkg::dataWidth-1:0]    rtData
);

    logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];

    // r0 is an ordinary register here
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Reads see the old value until the edge
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

// ==== executeUnit.sv ====
module executeUnit (
    input  cpuPkg::ctrlT                 ctrl,
    input  logic [cpuPkg::dataWidth-1:0] instr,
    input  logic [cpuPkg::dataWidth-1:0] rsData,
    input  logic [cpuPkg::dataWidth-1:0] rtData,
    output logic [cpuPkg::dataWidth-1:0] aluResult,
    output logic                         branchTaken,
    output logic [cpuPkg::dataWidth-1:0] jrTarget
);

    logic [cpuPkg::dataWidth-1:0] imm5Ext;
    logic [cpuPkg::dataWidth-1:0] imm8Sext;
    logic [cpuPkg::dataWidth-1:0] imm8Zext;
    logic [cpuPkg::dataWidth-1:0] opB;

    // Immediate forms
    assign imm5Ext = ctrl.isSignExtend ? {{11{instr[4]}}, instr[4:0]} : {11'b0, instr[4:0]};
    assign imm8Sext = {{8{instr[7]}}, instr[7:0]};
    assign imm8Zext = {8'b0, instr[7:0]};

    // Second operand
    always_comb begin
        if (ctrl.aluSrc) begin
            opB = rtData;
        end else if (ctrl.isIType1) begin
            opB = imm5Ext;
        end else if (ctrl.isSlbi) begin
            opB = imm8Zext;
        end else begin
            opB = imm8Sext;
        end
    end

    always_comb begin
        aluResult = '0;
        case (ctrl.aluOp)
            cpuPkg::aluAdd: aluResult = rsData + opB;
            // Subtracts take rs from the other operand
            cpuPkg::aluSub: aluResult = opB - rsData;
            cpuPkg::aluXor: aluResult = rsData ^ opB;
            cpuPkg::aluAndn: aluResult = rsData & ~opB;
            // Branch conditions land in bit 0
            cpuPkg::aluBeqz: aluResult[0] = (rsData == '0);
            cpuPkg::aluBnez: aluResult[0] = (rsData != '0);
            cpuPkg::aluBltz: aluResult[0] = rsData[cpuPkg::dataWidth-1];
            cpuPkg::aluBgez: aluResult[0] = ~rsData[cpuPkg::dataWidth-1];
            // Set forms give 1 or 0, signed compare
            cpuPkg::aluSeq: aluResult[0] = (rsData == opB);
            cpuPkg::aluSlt: aluResult[0] = ($signed(rsData) < $signed(opB));
            cpuPkg::aluSle: aluResult[0] = ($signed(rsData) <= $signed(opB));
            cpuPkg::aluLbi: aluResult = opB;
            // Low byte of rs moves up, immediate fills the bottom
            cpuPkg::aluSlbi: aluResult = {rsData[7:0], 8'b0} | opB;
            default: aluResult = '0;
        endcase
    end

    assign branchTaken = ctrl.isBranch & aluResult[0];
    // JR and JALR target
    assign jrTarget = rsData + imm8Sext;

endmodule

// ==== controlUnit.sv ====
module controlUnit (
    input  logic [cpuPkg::opcodeWidth-1:0] opcode,
    input  logic                           fftCalculating,
    output cpuPkg::ctrlT                   ctrl,
    output cpuPkg::accelCmdT               accelCmd,
    output logic                           blockInstruction
);

    cpuPkg::aluOpT aluOp;

    always_comb begin
        // Idle defaults, each opcode turns on only what it needs
        ctrl = '0;
        accelCmd = '0;
        blockInstruction = 1'b0;
        case (opcode)
            cpuPkg::opHalt: begin
                ctrl.halt = 1'b1;
            end
            cpuPkg::opNop: begin
                ctrl.nop = 1'b1;
            end
            // Starts wait for the accelerator, issue on the first idle cycle
            cpuPkg::opStartF: begin
                accelCmd.startF = ~fftCalculating;
                blockInstruction = fftCalculating;
            end
            cpuPkg::opStartI: begin
                accelCmd.startI = ~fftCalculating;
                blockInstruction = fftCalculating;
            end
            // LoadF goes out even while busy
            cpuPkg::opLoadF: begin
                accelCmd.loadF = 1'b1;
            end
            // Signed 5-bit immediate forms
            cpuPkg::opAddi, cpuPkg::opSubi: begin
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            // Logic immediates are zero extended
            cpuPkg::opXori, cpuPkg::opAndni: begin
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
            end
            // Address is rs plus signed immediate
            cpuPkg::opSt: begin
                ctrl.isSignExtend = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            cpuPkg::opLd: begin
                ctrl.isSignExtend = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Store, then rs takes the effective address
            cpuPkg::opStu: begin
                ctrl.isSignExtend = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.rsWrite = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Register forms, rd in bits 4:2
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opXor, cpuPkg::opAndn,
            cpuPkg::opSeq, cpuPkg::opSlt, cpuPkg::opSle: begin
                ctrl.regDst = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::opBeqz, cpuPkg::opBnez, cpuPkg::opBltz, cpuPkg::opBgez: begin
                ctrl.isBranch = 1'b1;
            end
            cpuPkg::opLbi: begin
                ctrl.rsWrite = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::opSlbi: begin
                ctrl.rsWrite = 1'b1;
                ctrl.isSlbi = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::opJr: begin
                ctrl.isJr = 1'b1;
            end
            cpuPkg::opJalr: begin
                ctrl.isJal = 1'b1;
                ctrl.isJr = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::opJ: begin
                ctrl.isJump = 1'b1;
            end
            cpuPkg::opJal: begin
                ctrl.isJal = 1'b1;
                ctrl.isJump = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // RFE lands here too, no exception PC in this core
            default: begin
            end
        endcase

        // ALU operation, add covers addresses and unused slots
        case (opcode)
            cpuPkg::opSubi, cpuPkg::opSub: aluOp = cpuPkg::aluSub;
            cpuPkg::opXori, cpuPkg::opXor: aluOp = cpuPkg::aluXor;
            cpuPkg::opAndni, cpuPkg::opAndn: aluOp = cpuPkg::aluAndn;
            cpuPkg::opSeq: aluOp = cpuPkg::aluSeq;
            cpuPkg::opSlt: aluOp = cpuPkg::aluSlt;
            cpuPkg::opSle: aluOp = cpuPkg::aluSle;
            cpuPkg::opBeqz: aluOp = cpuPkg::aluBeqz;
            cpuPkg::opBnez: aluOp = cpuPkg::aluBnez;
            cpuPkg::opBltz: aluOp = cpuPkg::aluBltz;
            cpuPkg::opBgez: aluOp = cpuPkg::aluBgez;
            cpuPkg::opLbi: aluOp = cpuPkg::aluLbi;
            cpuPkg::opSlbi: aluOp = cpuPkg::aluSlbi;
            default: aluOp = cpuPkg::aluAdd;
        endcase
        ctrl.aluOp = aluOp;
    end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    // Datapath widths
    localparam int dataWidth = 16;
    localparam int regAddrWidth = 3;
    localparam int opcodeWidth = 5;
    localparam int numRegs = 8;

    // JAL and JALR write the return address here
    localparam logic [regAddrWidth-1:0] linkReg = 3'd7;
    // Byte distance to the next instruction
    localparam logic [dataWidth-1:0] pcStep = 16'd2;

    // Special instructions
    localparam logic [opcodeWidth-1:0] opHalt   = 5'b00000;
    localparam logic [opcodeWidth-1:0] opNop    = 5'b00001;
    localparam logic [opcodeWidth-1:0] opStartF = 5'b00010;
    localparam logic [opcodeWidth-1:0] opStartI = 5'b00011;
    localparam logic [opcodeWidth-1:0] opLoadF  = 5'b11111;
    localparam logic [opcodeWidth-1:0] opRfe    = 5'b10101;
    // I format 1
    localparam logic [opcodeWidth-1:0] opAddi   = 5'b01000;
    localparam logic [opcodeWidth-1:0] opSubi   = 5'b01001;
    localparam logic [opcodeWidth-1:0] opXori   = 5'b01010;
    localparam logic [opcodeWidth-1:0] opAndni  = 5'b01011;
    localparam logic [opcodeWidth-1:0] opSt     = 5'b10000;
    localparam logic [opcodeWidth-1:0] opLd     = 5'b10001;
    localparam logic [opcodeWidth-1:0] opStu    = 5'b10011;
    // R format
    localparam logic [opcodeWidth-1:0] opAdd    = 5'b11000;
    localparam logic [opcodeWidth-1:0] opSub    = 5'b11001;
    localparam logic [opcodeWidth-1:0] opXor    = 5'b11010;
    localparam logic [opcodeWidth-1:0] opAndn   = 5'b11011;
    localparam logic [opcodeWidth-1:0] opSeq    = 5'b11100;
    localparam logic [opcodeWidth-1:0] opSlt    = 5'b11101;
    localparam logic [opcodeWidth-1:0] opSle    = 5'b11110;
    // I format 2
    localparam logic [opcodeWidth-1:0] opBeqz   = 5'b01100;
    localparam logic [opcodeWidth-1:0] opBnez   = 5'b01101;
    localparam logic [opcodeWidth-1:0] opBltz   = 5'b01110;
    localparam logic [opcodeWidth-1:0] opBgez   = 5'b01111;
    localparam logic [opcodeWidth-1:0] opLbi    = 5'b10100;
    localparam logic [opcodeWidth-1:0] opSlbi   = 5'b10010;
    localparam logic [opcodeWidth-1:0] opJr     = 5'b00101;
    localparam logic [opcodeWidth-1:0] opJalr   = 5'b00111;
    // J format
    localparam logic [opcodeWidth-1:0] opJ      = 5'b00100;
    localparam logic [opcodeWidth-1:0] opJal    = 5'b00110;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluXor  = 4'd2,
        aluAndn = 4'd3,
        aluBeqz = 4'd4,
        aluBnez = 4'd5,
        aluBltz = 4'd6,
        aluBgez = 4'd7,
        aluSeq  = 4'd8,
        aluSlt  = 4'd9,
        aluSle  = 4'd10,
        aluLbi  = 4'd11,
        aluSlbi = 4'd12
    } aluOpT;

    // Decoder outputs, one bundle per instruction
    typedef struct packed {
        logic  isJal;
        logic  regDst;
        logic  rsWrite;
        logic  regWrite;
        logic  aluSrc;
        logic  isSignExtend;
        logic  isIType1;
        logic  isBranch;
        logic  halt;
        logic  nop;
        logic  memWrite;
        logic  memRead;
        logic  memToReg;
        logic  isJr;
        logic  isSlbi;
        logic  isJump;
        aluOpT aluOp;
    } ctrlT;

    // Commands to the FFT accelerator
    typedef struct packed {
        logic startF;
        logic startI;
        logic loadF;
    } accelCmdT;

    // Wishbone master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [dataWidth-1:0] adr;
        logic [dataWidth-1:0] datW;
    } wbReqT;

    // Wishbone slave to master
    typedef struct packed {
        logic                 ack;
        logic [dataWidth-1:0] datR;
    } wbRspT;

endpackage
